// ==== flist.f ====
hdl/pulse_pkg.sv
hdl/pulse_params_if.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/frame_decoder.sv
hdl/param_bank.sv
hdl/pulse_sequencer.sv
hdl/pulse_control_top.sv
tests/pulse_control_tb.sv
tests/pulse_control_asserts.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pulse controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module pulse_control_tb -f flist.f

out=$(./obj_dir/Vpulse_control_tb)
echo "$out"

# Pass only if the testbench printed its pass message
echo "$out" | grep -q "Test completed successfully"

// ==== tests/pulse_control_asserts.sv ====
module pulse_control_asserts (
	input logic clk,
	input logic arst_n,
	input logic cmd_valid,
	input logic tx,
	input logic tx_busy,
	input logic pulse1,
	input logic blank,   // Blank flag in force for the current period
	input logic sync
);

	// Frame strobe is a single cycle
	cmd_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) cmd_valid |=> !cmd_valid)
		else $error("cmd_valid stayed high for more than one cycle");

	// Line idles at mark level
	tx_idle_high: assert property (@(posedge clk) disable iff (!arst_n) !tx_busy |-> tx)
		else $error("tx low while the transmitter is idle");

	// Shadow flag and pulse1 both move at the period start
	blank_holds_pulse1: assert property (@(posedge clk) disable iff (!arst_n) blank |-> !pulse1)
		else $error("pulse1 high while blank is set");

	sync_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) sync |=> !sync)
		else $error("sync stayed high for more than one cycle");

endmodule

bind pulse_control_top pulse_control_asserts asserts_i (
	.clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid), .tx(tx), .tx_busy(tx_busy),
	.pulse1(pulse1), .blank(pulse_sequencer_i.sh_blank), .sync(sync)
);

// ==== tests/pulse_control_tb.sv ====
module pulse_control_tb;

	localparam int cpb        = 8;    // Clocks per UART bit
	localparam int wait_limit = 6000; // Clocks allowed for one wait

	logic       clk = 1'b0;
	logic       arst_n;
	logic       rx;
	logic       tx;
	logic [6:0] pre_att;
	logic       sync;
	logic       pulse1;
	logic       pulse2;

	// Register model, starts at the DUT init values
	longint     ex_period = 400;
	longint     ex_p1     = 10;
	longint     ex_delay  = 30;
	longint     ex_p2     = 10;
	bit         ex_cpmg   = 1'b0;
	bit         ex_blank  = 1'b0;
	logic [6:0] ex_att    = '0;

	logic [31:0]      lcg_state = 32'h43ff57ae;
	pulse_pkg::byte_t reply_q[$]; // Bytes caught on tx
	string            test_name;
	int               tests_run  = 0;
	int               checks_run = 0;
	int               errors     = 0;
	int               test_err0  = 0; // Error count when the test began
	bit               timed_out  = 1'b0; // A wait gave up

	// Results of the last complete period, updated at each sync
	int sync_cnt = 0;
	int m_len;
	int m_p1_hi;
	int m_p1_first;
	int m_p2_hi;
	int m_nrise;
	int m_rise [8];

	// Period in progress
	int   pos       = 0;
	int   p1_hi     = 0;
	int   p1_first  = -1;
	int   p2_hi     = 0;
	int   nrise     = 0;
	int   rise [8];
	logic p2_prev   = 1'b0;
	bit   seen_sync = 1'b0;

	pulse_control_top #(
		.clks_per_bit(cpb), .init_period(32'd400), .init_p1_width(16'd10),
		.init_delay(16'd30), .init_p2_width(16'd10), .init_cpmg(1'b0)
	) dut_i (
		.clk(clk), .arst_n(arst_n), .rx(rx), .tx(tx), .pre_att(pre_att),
		.sync(sync), .pulse1(pulse1), .pulse2(pulse2)
	);

	always #50 clk = ~clk;

	// Edge positions counted from the sync cycle
	always @(posedge clk) begin
		if (sync) begin
			if (seen_sync) begin
				m_len      <= pos;
				m_p1_hi    <= p1_hi;
				m_p1_first <= p1_first;
				m_p2_hi    <= p2_hi;
				m_nrise    <= nrise;
				m_rise     <= rise;
			end
			sync_cnt <= sync_cnt + 1;
			seen_sync = 1'b1;
			pos      = 0;
			p1_hi    = 0;
			p1_first = -1;
			p2_hi    = 0;
			nrise    = 0;
			p2_prev  = 1'b0;
		end
		if (pulse1) begin
			p1_hi++;
			if (p1_first < 0) p1_first = pos;
		end
		if (pulse2) begin
			p2_hi++;
			if (!p2_prev && nrise < 8) begin // Rising edge of pulse 2
				rise[nrise] = pos;
				nrise++;
			end
		end
		p2_prev = pulse2;
		pos++;
	end

	// Reply receiver, samples mid-bit
	always @(posedge clk) begin : catch_reply
		pulse_pkg::byte_t b;
		if (arst_n && !tx) begin
			repeat (cpb / 2) @(posedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (cpb) @(posedge clk);
				b[i] = tx;
			end
			repeat (cpb) @(posedge clk);
			check_value("reply stop bit", 1, tx);
			reply_q.push_back(b);
		end
	end

	// Closes the run once a wait has given up
	initial begin
		wait (timed_out);
		$display("Test failed");
		$finish;
	end

	task automatic check_value(input string what, input longint expected, input longint actual);
		checks_run++;
		if (expected != actual) begin
			errors++;
			$display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	task automatic timeout_abort(input string what);
		$display("Timeout in test %s: %s", test_name, what);
		timed_out = 1'b1;
		forever @(posedge clk); // Main sequence stops here
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Expected reply, mod-256 sum of the data bytes
	function automatic pulse_pkg::byte_t ref_checksum(input logic [31:0] d);
		int sum;
		sum = 0;
		for (int i = 0; i < pulse_pkg::frame_data_bytes; i++) sum += int'(d[8*i +: 8]);
		return pulse_pkg::byte_t'(sum % 256);
	endfunction

	// Start of the k-th pulse 2, -1 if there is none
	function automatic longint ref_p2_rise(input int k);
		longint s;
		s = ex_p1 + ex_delay + k * (2 * ex_delay + ex_p2);
		if ((k > 0 && !ex_cpmg) || s >= ex_period) return -1;
		return s;
	endfunction

	// Pulse 2 high cycles per period, last one cut at the period end
	function automatic longint ref_p2_high();
		longint hi;
		longint s;
		hi = 0;
		for (int k = 0; k < 8; k++) begin
			s = ref_p2_rise(k);
			if (s >= 0) hi += (s + ex_p2 > ex_period) ? ex_period - s : ex_p2;
		end
		return hi;
	endfunction

	task automatic apply_model(input pulse_pkg::byte_t code, input logic [31:0] d);
		case (code)
			pulse_pkg::cmd_set_delay:    ex_delay  = d[15:0];
			pulse_pkg::cmd_set_period:   ex_period = d;
			pulse_pkg::cmd_set_pulse1:   ex_p1     = d[15:0];
			pulse_pkg::cmd_set_pulse2:   ex_p2     = d[15:0];
			pulse_pkg::cmd_blank_pulse1: ex_blank  = d[0];
			pulse_pkg::cmd_set_cpmg:     ex_cpmg   = d[0];
			pulse_pkg::cmd_set_att:      ex_att    = d[6:0];
			default: ;
		endcase
	endtask

	task automatic send_byte(input pulse_pkg::byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0}; // Stop, data, start
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rx <= bits[i];
			repeat (cpb - 1) @(posedge clk);
		end
	endtask

	task automatic send_frame(input pulse_pkg::byte_t code, input logic [31:0] d);
		for (int i = 0; i < pulse_pkg::frame_data_bytes; i++) send_byte(d[8*i +: 8]);
		send_byte(code);
	endtask

	task automatic wait_replies(input int n);
		int t;
		t = 0;
		while (reply_q.size() < n && t < wait_limit) begin
			@(posedge clk);
			t++;
		end
		if (reply_q.size() < n) timeout_abort("no checksum reply arrived on tx");
	endtask

	task automatic wait_periods(input int n);
		int t;
		int target;
		t = 0;
		target = sync_cnt + n;
		while (sync_cnt < target && t < wait_limit) begin
			@(posedge clk);
			t++;
		end
		if (sync_cnt < target) timeout_abort("sync pulses stopped coming");
	endtask

	// One frame, its reply checked against the data bytes
	task automatic run_command(input pulse_pkg::byte_t code, input logic [31:0] d);
		pulse_pkg::byte_t r;
		send_frame(code, d);
		wait_replies(1);
		r = reply_q.pop_front();
		check_value($sformatf("checksum code %0d", code), ref_checksum(d), r);
		apply_model(code, d);
	endtask

	task automatic check_timing();
		int n;
		n = 0;
		check_value("period length", ex_period, m_len);
		check_value("pulse1 high cycles", ex_blank ? 0 : ex_p1, m_p1_hi);
		check_value("pulse1 start", ex_blank ? -1 : 0, m_p1_first);
		for (int k = 0; k < 8; k++) begin
			if (ref_p2_rise(k) >= 0) begin
				check_value($sformatf("pulse2 start %0d", k), ref_p2_rise(k), m_rise[k]);
				n++;
			end
		end
		check_value("pulse2 count", n, m_nrise);
		check_value("pulse2 high cycles", ref_p2_high(), m_p2_hi);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err0 = errors;
		tests_run++;
	endtask

	task automatic end_test();
		$display("test %s: %s", test_name, (errors == test_err0) ? "passed" : "failed");
	endtask

	initial begin
		logic [31:0]      d;
		pulse_pkg::byte_t code;
		pulse_pkg::byte_t r;
		arst_n = 1'b0;
		rx     = 1'b1; // Line idle
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;

		begin_test("reset defaults");
		wait_periods(3); // Second full period
		check_timing();
		check_value("pre_att", 0, pre_att);
		end_test();

		begin_test("timing registers");
		run_command(pulse_pkg::cmd_set_period, 32'd300);
		run_command(pulse_pkg::cmd_set_delay, 32'h5a5a_0014); // Upper half ignored
		run_command(pulse_pkg::cmd_set_pulse1, 32'd12);
		run_command(pulse_pkg::cmd_set_pulse2, 32'd8);
		wait_periods(2);
		check_timing();
		end_test();

		begin_test("random frames");
		for (int i = 0; i < 6; i++) begin
			d    = next_random();
			code = pulse_pkg::byte_t'(6 + next_random() % 10); // Attenuator or unknown
			run_command(code, d);
		end
		wait_periods(2);
		check_timing();
		check_value("pre_att", ex_att, pre_att);
		end_test();

		begin_test("cpmg train");
		run_command(pulse_pkg::cmd_set_cpmg, 32'd1);
		wait_periods(2);
		check_timing();
		run_command(pulse_pkg::cmd_set_cpmg, 32'd0);
		wait_periods(2);
		check_timing();
		end_test();

		begin_test("blank and attenuator");
		run_command(pulse_pkg::cmd_blank_pulse1, 32'd1);
		run_command(pulse_pkg::cmd_set_att, 32'h0000_00a5); // Bit 7 dropped
		wait_periods(2);
		check_timing();
		check_value("pre_att", 7'h25, pre_att);
		run_command(pulse_pkg::cmd_blank_pulse1, 32'd0);
		end_test();

		begin_test("back to back");
		send_frame(8'd8, 32'h1122_3344);
		send_frame(pulse_pkg::cmd_set_att, 32'hfedc_ba98); // First reply goes out meanwhile
		wait_replies(2);
		r = reply_q.pop_front();
		check_value("first reply", ref_checksum(32'h1122_3344), r);
		r = reply_q.pop_front();
		check_value("second reply", ref_checksum(32'hfedc_ba98), r);
		apply_model(pulse_pkg::cmd_set_att, 32'hfedc_ba98);
		@(posedge clk);
		check_value("pre_att", ex_att, pre_att);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks_run, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== hdl/pulse_control_top.sv ====
module pulse_control_top #(
	parameter int                 clks_per_bit  = 104,
	parameter pulse_pkg::period_t init_period   = 32'd10000,
	parameter pulse_pkg::width_t  init_p1_width = 16'd40,
	parameter pulse_pkg::width_t  init_delay    = 16'd150,
	parameter pulse_pkg::width_t  init_p2_width = 16'd40,
	parameter bit                 init_cpmg     = 1'b0
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       rx,
	output logic       tx,
	output logic [6:0] pre_att,
	output logic       sync,
	output logic       pulse1,
	output logic       pulse2
);

	logic             rx_valid;  // Byte strobe
	pulse_pkg::byte_t rx_byte;
	logic             cmd_valid; // Frame strobe
	pulse_pkg::byte_t cmd_code;
	logic [31:0]      cmd_data;
	logic             tx_start;  // Reply strobe
	pulse_pkg::byte_t tx_byte;
	logic             tx_busy;

	pulse_params_if params ();

	uart_rx #(.clks_per_bit(clks_per_bit)) uart_rx_i (
		.clk(clk), .arst_n(arst_n),
		.rx(rx), .rx_valid(rx_valid), .rx_byte(rx_byte)
	);

	frame_decoder frame_decoder_i (
		.clk(clk), .arst_n(arst_n),
		.rx_valid(rx_valid), .rx_byte(rx_byte),
		.cmd_valid(cmd_valid), .cmd_code(cmd_code), .cmd_data(cmd_data)
	);

	param_bank #(
		.init_period(init_period), .init_p1_width(init_p1_width), .init_delay(init_delay),
		.init_p2_width(init_p2_width), .init_cpmg(init_cpmg)
	) param_bank_i (
		.clk(clk), .arst_n(arst_n),
		.cmd_valid(cmd_valid), .cmd_code(cmd_code), .cmd_data(cmd_data),
		.params(params.bank), .pre_att(pre_att),
		.tx_busy(tx_busy), .tx_start(tx_start), .tx_byte(tx_byte)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) uart_tx_i (
		.clk(clk), .arst_n(arst_n),
		.tx_start(tx_start), .tx_byte(tx_byte), .tx(tx), .tx_busy(tx_busy)
	);

	pulse_sequencer pulse_sequencer_i (
		.clk(clk), .arst_n(arst_n), .params(params.seq),
		.sync(sync), .pulse1(pulse1), .pulse2(pulse2)
	);

endmodule

// ==== hdl/pulse_sequencer.sv ====
module pulse_sequencer (
	input  logic        clk,
	input  logic        arst_n,
	pulse_params_if.seq params,
	output logic        sync,
	output logic        pulse1,
	output logic        pulse2
);

	pulse_pkg::period_t cnt;       // Cycle within the period
	pulse_pkg::period_t nxt_start; // Next pulse 2 start cycle
	pulse_pkg::period_t cur_next;
	pulse_pkg::period_t step;      // CPMG spacing, 2*delay + p2_width
	pulse_pkg::width_t  p2_left;   // Pulse 2 cycles still to go

	// Shadows, frozen for the whole period
	pulse_pkg::period_t sh_period;
	pulse_pkg::width_t  sh_p1_width;
	pulse_pkg::width_t  sh_delay;
	pulse_pkg::width_t  sh_p2_width;
	logic               sh_cpmg;
	logic               sh_blank;

	// Values in force this cycle, live ones on cycle 0
	pulse_pkg::period_t cur_period;
	pulse_pkg::width_t  cur_p1_width;
	pulse_pkg::width_t  cur_delay;
	pulse_pkg::width_t  cur_p2_width;
	logic               cur_cpmg;
	logic               cur_blank;

	logic at_start; // Period cycle 0
	logic wrap;     // Last cycle of the period
	logic p2_hit;   // A pulse 2 starts here

	assign at_start     = (cnt == '0);
	assign cur_period   = at_start ? params.period : sh_period;
	assign cur_p1_width = at_start ? params.p1_width : sh_p1_width;
	assign cur_delay    = at_start ? params.delay : sh_delay;
	assign cur_p2_width = at_start ? params.p2_width : sh_p2_width;
	assign cur_cpmg     = at_start ? params.cpmg : sh_cpmg;
	assign cur_blank    = at_start ? params.blank : sh_blank;

	// 33-bit compare so period 0 behaves like period 1
	assign wrap     = ({1'b0, cnt} + 33'd1) >= {1'b0, cur_period};
	assign cur_next = at_start ? {16'b0, cur_p1_width} + {16'b0, cur_delay} : nxt_start;
	assign step     = {15'b0, cur_delay, 1'b0} + {16'b0, cur_p2_width};
	assign p2_hit   = (cnt == cur_next);

	always_ff @(posedge clk) begin
		if (at_start) begin
			sh_period   <= params.period;
			sh_p1_width <= params.p1_width;
			sh_delay    <= params.delay;
			sh_p2_width <= params.p2_width;
			sh_cpmg     <= params.cpmg;
			sh_blank    <= params.blank;
		end
	end

	// Outputs lag cnt by one cycle, all alike
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt       <= '0;
			nxt_start <= '0;
			p2_left   <= '0;
			sync      <= 1'b0;
			pulse1    <= 1'b0;
			pulse2    <= 1'b0;
		end else begin
			cnt    <= wrap ? '0 : cnt + 1'b1;
			sync   <= at_start;
			pulse1 <= !cur_blank && (cnt[31:16] == '0) && (cnt[15:0] < cur_p1_width);
			nxt_start <= (p2_hit && cur_cpmg) ? cur_next + step : cur_next; // Hahn, one hit only
			if (p2_hit) begin
				pulse2  <= (cur_p2_width != '0);
				p2_left <= (cur_p2_width != '0) ? cur_p2_width - 1'b1 : '0;
			end else if (at_start || p2_left == '0) begin
				pulse2  <= 1'b0; // New period cuts a late pulse
				p2_left <= '0;
			end else begin
				pulse2  <= 1'b1;
				p2_left <= p2_left - 1'b1;
			end
		end
	end

endmodule

// ==== hdl/param_bank.sv ====
module param_bank #(
	parameter pulse_pkg::period_t init_period   = 32'd10000,
	parameter pulse_pkg::width_t  init_p1_width = 16'd40,
	parameter pulse_pkg::width_t  init_delay    = 16'd150,
	parameter pulse_pkg::width_t  init_p2_width = 16'd40,
	parameter bit                 init_cpmg     = 1'b0
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             cmd_valid,
	input  pulse_pkg::byte_t cmd_code,
	input  logic [31:0]      cmd_data,
	pulse_params_if.bank     params,
	output pulse_pkg::att_t  pre_att,
	input  logic             tx_busy,
	output logic             tx_start,
	output pulse_pkg::byte_t tx_byte
);

	pulse_pkg::byte_t reply_sum;     // Checksum echoed to the host
	logic             reply_pending; // Reply waits for the transmitter

	// Modulo-256 sum of the four data bytes
	assign reply_sum = cmd_data[7:0] + cmd_data[15:8] + cmd_data[23:16] + cmd_data[31:24];

	// Goes out as soon as the line is free
	assign tx_start = reply_pending & ~tx_busy;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			params.period   <= init_period;
			params.p1_width <= init_p1_width;
			params.delay    <= init_delay;
			params.p2_width <= init_p2_width;
			params.cpmg     <= init_cpmg;
			params.blank    <= 1'b0;
			pre_att         <= '0;
			reply_pending   <= 1'b0;
		end else begin
			if (cmd_valid) begin
				case (cmd_code)
					pulse_pkg::cmd_set_delay:    params.delay    <= cmd_data[15:0];
					pulse_pkg::cmd_set_period:   params.period   <= cmd_data;
					pulse_pkg::cmd_set_pulse1:   params.p1_width <= cmd_data[15:0];
					pulse_pkg::cmd_set_pulse2:   params.p2_width <= cmd_data[15:0];
					pulse_pkg::cmd_blank_pulse1: params.blank    <= cmd_data[0];
					pulse_pkg::cmd_set_cpmg:     params.cpmg     <= cmd_data[0];
					pulse_pkg::cmd_set_att:      pre_att         <= cmd_data[6:0];
					default: ; // Unknown code, registers untouched
				endcase
			end
			if (cmd_valid) reply_pending <= 1'b1; // New reply wins over a launch
			else if (tx_start) reply_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid) tx_byte <= reply_sum;
	end

endmodule

// ==== hdl/frame_decoder.sv ====
module frame_decoder (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             rx_valid,
	input  pulse_pkg::byte_t rx_byte,
	output logic             cmd_valid,
	output pulse_pkg::byte_t cmd_code,
	output logic [31:0]      cmd_data
);

	localparam logic [2:0] last_data = 3'(pulse_pkg::frame_data_bytes); // Index of control byte

	logic [2:0] byte_cnt; // Bytes of the current frame seen so far

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			byte_cnt  <= '0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= 1'b0;
			if (rx_valid) begin
				if (byte_cnt == last_data) begin
					byte_cnt  <= '0; // Frame complete
					cmd_valid <= 1'b1;
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

	// Data bytes land at 8 * index, control byte is kept raw
	always_ff @(posedge clk) begin
		if (rx_valid) begin
			if (byte_cnt == last_data) cmd_code <= rx_byte;
			else cmd_data[{byte_cnt[1:0], 3'b000} +: 8] <= rx_byte;
		end
	end

endmodule

// ==== hdl/uart_tx.sv ====
module uart_tx #(
	parameter int clks_per_bit = 104
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             tx_start,
	input  pulse_pkg::byte_t tx_byte,
	output logic             tx,
	output logic             tx_busy
);

	localparam int cnt_w = $clog2(clks_per_bit + 1);
	typedef logic [cnt_w-1:0] cnt_t;
	localparam cnt_t last_cnt = cnt_t'(clks_per_bit - 1); // Last clock of a bit

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

	state_t           state;
	cnt_t             bit_cnt; // Bit timer
	logic [2:0]       bit_idx; // Data bit being sent
	pulse_pkg::byte_t shreg;   // Remaining data bits, LSB on the line

	assign tx_busy = (state != st_idle);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= st_idle;
			bit_cnt <= '0;
			bit_idx <= '0;
			tx      <= 1'b1; // Mark level
		end else begin
			if (state == st_idle) begin
				bit_cnt <= '0;
				bit_idx <= '0;
				if (tx_start) begin
					tx    <= 1'b0; // Start bit
					state <= st_start;
				end
			end else if (bit_cnt != last_cnt) begin
				bit_cnt <= bit_cnt + 1'b1;
			end else begin
				bit_cnt <= '0;
				case (state)
					st_start: begin
						tx    <= shreg[0];
						state <= st_data;
					end
					st_data: begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							tx    <= 1'b1; // Stop bit
							state <= st_stop;
						end else begin
							tx <= shreg[1]; // Next bit after the shift
						end
					end
					default: state <= st_idle; // Stop bit done
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && tx_start) shreg <= tx_byte;
		else if (state == st_data && bit_cnt == last_cnt) shreg <= shreg >> 1;
	end

endmodule

// ==== hdl/uart_rx.sv ====
module uart_rx #(
	parameter int clks_per_bit = 104
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             rx,
	output logic             rx_valid,
	output pulse_pkg::byte_t rx_byte
);

	localparam int cnt_w = $clog2(clks_per_bit + 1);
	typedef logic [cnt_w-1:0] cnt_t;
	localparam cnt_t last_cnt = cnt_t'(clks_per_bit - 1);  // End of one bit time
	localparam cnt_t half_cnt = cnt_t'(clks_per_bit / 2 - 1); // Middle of start bit

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

	state_t     state;
	logic       rx_meta; // First synchronizer stage
	logic       rx_sync; // Safe to use in logic
	cnt_t       bit_cnt; // Clocks within the current bit
	logic [2:0] bit_idx; // Data bit number

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_meta  <= 1'b1; // Line idles high
			rx_sync  <= 1'b1;
			state    <= st_idle;
			bit_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta  <= rx;
			rx_sync  <= rx_meta;
			rx_valid <= 1'b0; // Strobe by default
			case (state)
				st_idle: begin
					bit_cnt <= '0;
					if (!rx_sync) state <= st_start; // Falling edge of start bit
				end
				st_start: begin
					if (bit_cnt == half_cnt) begin
						bit_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? st_idle : st_data; // Glitch, not a start bit
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				st_data: begin
					if (bit_cnt == last_cnt) begin
						bit_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) state <= st_stop;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				st_stop: begin
					if (bit_cnt == last_cnt) begin
						rx_valid <= rx_sync; // Framing error drops the byte
						state    <= st_idle;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// LSB arrives first, shift in from the top
	always_ff @(posedge clk) begin
		if (state == st_data && bit_cnt == last_cnt) rx_byte <= {rx_sync, rx_byte[7:1]};
	end

endmodule

// ==== hdl/pulse_params_if.sv ====
interface pulse_params_if;

	pulse_pkg::period_t period;  // Repetition period in clocks
	pulse_pkg::width_t p1_width; // Pulse 1 high time
	pulse_pkg::width_t delay;    // Gap after pulse 1, half spacing in CPMG
	pulse_pkg::width_t p2_width; // Pulse 2 high time
	logic cpmg;                  // Repeat pulse 2 through the period
	logic blank;                 // Hold pulse 1 low

	// Register bank owns the values
	modport bank (
		output period,
		output p1_width,
		output delay,
		output p2_width,
		output cpmg,
		output blank
	);

	// Sequencer only reads them
	modport seq (
		input period,
		input p1_width,
		input delay,
		input p2_width,
		input cpmg,
		input blank
	);

endinterface

// ==== hdl/pulse_pkg.sv ====
package pulse_pkg;

	// One serial byte
	typedef logic [7:0] byte_t;

	// Period length in clock cycles
	typedef logic [31:0] period_t;

	// Pulse width or delay in clock cycles
	typedef logic [15:0] width_t;

	// Pre-attenuator setting
	typedef logic [6:0] att_t;

	// Control byte codes, sent last in each frame
	localparam byte_t cmd_set_delay    = 8'd0; // Delay between pulse 1 and pulse 2
	localparam byte_t cmd_set_period   = 8'd1; // Full 32-bit repetition period
	localparam byte_t cmd_set_pulse1   = 8'd2; // Pulse 1 width
	localparam byte_t cmd_set_pulse2   = 8'd3; // Pulse 2 width
	localparam byte_t cmd_blank_pulse1 = 8'd4; // Suppress pulse 1, data bit 0
	localparam byte_t cmd_set_cpmg     = 8'd5; // CPMG train on/off, data bit 0
	localparam byte_t cmd_set_att      = 8'd6; // Attenuator, low seven bits

	// Data bytes ahead of the control byte, least significant first
	localparam int frame_data_bytes = 4;

endpackage
